//--- include/mm_ram_macros.svh
// address map, widths and status codes of the simulation memory, included by RTL and checker
`ifndef MM_RAM_MACROS_SVH
`define MM_RAM_MACROS_SVH

// byte-address width of the RAM, 64 KiB
`define MM_RAM_ADDR_WIDTH 16

// width of one instruction fetch line in bits
`define MM_INSTR_WIDTH 128

// timer registers
`define MM_ADDR_TIMER_MASK 32'h1500_0000
`define MM_ADDR_TIMER_COUNT 32'h1500_0004

// test-status and exit registers
`define MM_ADDR_STATUS 32'h2000_0000
`define MM_ADDR_EXIT 32'h2000_0004

// value written to the status register by a passing test
`define MM_STATUS_PASS_CODE 32'd123456789

// value written to the status register by a failing test
`define MM_STATUS_FAIL_CODE 32'd1

// interrupt id of the timer, also the mask bit that enables it
`define MM_TIMER_IRQ_ID 7

`endif

//--- logic/mm_addr_decode.sv
// data-port decoder, routes each request to RAM or a peripheral and returns rvalid and read data
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module mm_addr_decode (
    input  logic                             clk_i,
    input  logic                             rst_ni,

    // data port from the core
    input  logic                             data_req_i,
    input  mm_ram_pkg::word_t                data_addr_i,
    input  logic                             data_we_i,
    input  mm_ram_pkg::byte_en_t             data_be_i,
    input  mm_ram_pkg::word_t                data_wdata_i,
    output logic                             data_gnt_o,
    output logic                             data_rvalid_o,
    output mm_ram_pkg::word_t                data_rdata_o,

    // RAM data port
    output logic                             ram_req_o,
    output logic                             ram_we_o,
    output logic [`MM_RAM_ADDR_WIDTH-1:0]    ram_addr_o,
    output mm_ram_pkg::word_t                ram_wdata_o,
    output mm_ram_pkg::byte_en_t             ram_be_o,
    input  mm_ram_pkg::word_t                ram_rdata_i,

    // peripheral writes
    output logic                             timer_mask_we_o,
    output logic                             timer_count_we_o,
    output logic                             status_we_o,
    output logic                             exit_we_o,
    output mm_ram_pkg::word_t                per_wdata_o
);
    import mm_ram_pkg::*;

    // everything below this byte address is RAM
    localparam word_t RAM_BYTES = word_t'(1) << `MM_RAM_ADDR_WIDTH;

    data_target_t target;
    logic         per_write;

    // response stage
    logic         rvalid_q;
    logic         rd_ram_q;

    always_comb begin
        target = TGT_NONE;
        if (data_addr_i < RAM_BYTES) begin
            target = TGT_RAM;
        end else if (data_addr_i == `MM_ADDR_TIMER_MASK) begin
            target = TGT_TIMER_MASK;
        end else if (data_addr_i == `MM_ADDR_TIMER_COUNT) begin
            target = TGT_TIMER_COUNT;
        end else if (data_addr_i == `MM_ADDR_STATUS) begin
            target = TGT_STATUS;
        end else if (data_addr_i == `MM_ADDR_EXIT) begin
            target = TGT_EXIT;
        end
    end

    // every request is accepted at once, whatever its target
    assign data_gnt_o = data_req_i;

    assign ram_req_o   = data_req_i && (target == TGT_RAM);
    assign ram_we_o    = data_we_i;
    assign ram_addr_o  = data_addr_i[`MM_RAM_ADDR_WIDTH-1:0];
    assign ram_wdata_o = data_wdata_i;
    assign ram_be_o    = data_be_i;

    // peripherals are write only, unmapped writes fall through
    assign per_write        = data_req_i && data_we_i;
    assign timer_mask_we_o  = per_write && (target == TGT_TIMER_MASK);
    assign timer_count_we_o = per_write && (target == TGT_TIMER_COUNT);
    assign status_we_o      = per_write && (target == TGT_STATUS);
    assign exit_we_o        = per_write && (target == TGT_EXIT);
    assign per_wdata_o      = data_wdata_i;

    // one cycle response for reads and writes alike
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            rd_ram_q <= 1'b0;
        end else begin
            rvalid_q <= data_req_i;
            rd_ram_q <= data_req_i && !data_we_i && (target == TGT_RAM);
        end
    end

    assign data_rvalid_o = rvalid_q;

    // only RAM returns data, any other read gives zero
    assign data_rdata_o = rd_ram_q ? ram_rdata_i : '0;

endmodule

//--- logic/mm_dp_ram.sv
// dual-port byte RAM with a wide read-only instruction port and a byte-enabled data port
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module mm_dp_ram (
    input  logic                             clk_i,
    input  logic                             rst_ni,

    // instruction port, read only
    input  logic                             instr_en_i,
    input  logic [`MM_RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic [`MM_INSTR_WIDTH-1:0]       instr_rdata_o,
    output logic                             instr_rvalid_o,

    // data port
    input  logic                             data_en_i,
    input  logic                             data_we_i,
    input  logic [`MM_RAM_ADDR_WIDTH-1:0]    data_addr_i,
    input  mm_ram_pkg::word_t                data_wdata_i,
    input  mm_ram_pkg::byte_en_t             data_be_i,
    output mm_ram_pkg::word_t                data_rdata_o
);
    import mm_ram_pkg::*;

    localparam int AW         = `MM_RAM_ADDR_WIDTH;
    localparam int LINE_BYTES = `MM_INSTR_WIDTH / 8;
    localparam int LINE_OFS   = $clog2(LINE_BYTES);
    localparam int WORD_BYTES = $bits(word_t) / 8;
    localparam int WORD_OFS   = $clog2(WORD_BYTES);

    logic [7:0] mem [0:(2**AW)-1];

    // instruction line, lowest address in the lowest byte
    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <=
                    mem[{instr_addr_i[AW-1:LINE_OFS], LINE_OFS'(i)}];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_en_i;
        end
    end

    // data port works on the aligned word
    always_ff @(posedge clk_i) begin
        if (data_en_i) begin
            if (data_we_i) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (data_be_i[b]) begin
                        mem[{data_addr_i[AW-1:WORD_OFS], WORD_OFS'(b)}] <=
                            data_wdata_i[8*b +: 8];
                    end
                end
            end else begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    data_rdata_o[8*b +: 8] <=
                        mem[{data_addr_i[AW-1:WORD_OFS], WORD_OFS'(b)}];
                end
            end
        end
    end

endmodule

//--- logic/mm_ram_pkg.sv
// shared data types of the simulation memory, imported by the RTL modules
package mm_ram_pkg;

    // one data-port word
    typedef logic [31:0] word_t;

    // byte enable of a data word
    typedef logic [3:0] byte_en_t;

    // interrupt id as acknowledged by the core
    typedef logic [5:0] irq_id_t;

    // where a data request lands
    typedef enum logic [2:0] {
        TGT_RAM         = 3'd0,
        TGT_TIMER_MASK  = 3'd1,
        TGT_TIMER_COUNT = 3'd2,
        TGT_STATUS      = 3'd3,
        TGT_EXIT        = 3'd4,
        TGT_NONE        = 3'd5
    } data_target_t;

endpackage

//--- logic/mm_ram_top.sv
// top level of the simulation memory, connects the core ports to RAM, timer and status unit
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module mm_ram_top (
    input  logic                             clk_i,
    input  logic                             rst_ni,

    input  logic                             instr_req_i,
    input  logic [`MM_RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                             instr_gnt_o,
    output logic                             instr_rvalid_o,
    output logic [`MM_INSTR_WIDTH-1:0]       instr_rdata_o,

    input  logic                             data_req_i,
    input  mm_ram_pkg::word_t                data_addr_i,
    input  logic                             data_we_i,
    input  mm_ram_pkg::byte_en_t             data_be_i,
    input  mm_ram_pkg::word_t                data_wdata_i,
    output logic                             data_gnt_o,
    output logic                             data_rvalid_o,
    output mm_ram_pkg::word_t                data_rdata_o,

    input  mm_ram_pkg::irq_id_t              irq_id_i,
    input  logic                             irq_ack_i,

    output logic                             irq_timer_o,
    output logic                             tests_passed_o,
    output logic                             tests_failed_o,
    output logic                             exit_valid_o,
    output mm_ram_pkg::word_t                exit_value_o
);
    import mm_ram_pkg::*;

    // data port of the RAM
    logic                          ram_req;
    logic                          ram_we;
    logic [`MM_RAM_ADDR_WIDTH-1:0] ram_addr;
    word_t                         ram_wdata;
    byte_en_t                      ram_be;
    word_t                         ram_rdata;

    // peripheral write strobes
    logic                          timer_mask_we;
    logic                          timer_count_we;
    logic                          status_we;
    logic                          exit_we;
    word_t                         per_wdata;

    // the instruction port never stalls
    assign instr_gnt_o = instr_req_i;

    mm_addr_decode addr_decode_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .data_req_i       (data_req_i),
        .data_addr_i      (data_addr_i),
        .data_we_i        (data_we_i),
        .data_be_i        (data_be_i),
        .data_wdata_i     (data_wdata_i),
        .data_gnt_o       (data_gnt_o),
        .data_rvalid_o    (data_rvalid_o),
        .data_rdata_o     (data_rdata_o),
        .ram_req_o        (ram_req),
        .ram_we_o         (ram_we),
        .ram_addr_o       (ram_addr),
        .ram_wdata_o      (ram_wdata),
        .ram_be_o         (ram_be),
        .ram_rdata_i      (ram_rdata),
        .timer_mask_we_o  (timer_mask_we),
        .timer_count_we_o (timer_count_we),
        .status_we_o      (status_we),
        .exit_we_o        (exit_we),
        .per_wdata_o      (per_wdata)
    );

    mm_dp_ram dp_ram_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_en_i     (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_rdata_o  (instr_rdata_o),
        .instr_rvalid_o (instr_rvalid_o),
        .data_en_i      (ram_req),
        .data_we_i      (ram_we),
        .data_addr_i    (ram_addr),
        .data_wdata_i   (ram_wdata),
        .data_be_i      (ram_be),
        .data_rdata_o   (ram_rdata)
    );

    mm_timer timer_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mask_we_i   (timer_mask_we),
        .count_we_i  (timer_count_we),
        .wdata_i     (per_wdata),
        .irq_ack_i   (irq_ack_i),
        .irq_id_i    (irq_id_i),
        .irq_timer_o (irq_timer_o)
    );

    mm_test_status test_status_i (
        .status_we_i    (status_we),
        .exit_we_i      (exit_we),
        .wdata_i        (per_wdata),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

endmodule

//--- logic/mm_test_status.sv
// decodes writes to the test-status and exit registers into pass, fail and exit signals
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module mm_test_status (
    input  logic                status_we_i,
    input  logic                exit_we_i,
    input  mm_ram_pkg::word_t   wdata_i,
    output logic                tests_passed_o,
    output logic                tests_failed_o,
    output logic                exit_valid_o,
    output mm_ram_pkg::word_t   exit_value_o
);

    // status codes other than pass or fail are ignored
    always_comb begin
        tests_passed_o = status_we_i && (wdata_i == `MM_STATUS_PASS_CODE);
        tests_failed_o = status_we_i && (wdata_i == `MM_STATUS_FAIL_CODE);
    end

    // exit code is only meaningful while exit_valid_o is high
    always_comb begin
        exit_valid_o = exit_we_i;
        exit_value_o = exit_we_i ? wdata_i : '0;
    end

endmodule

//--- logic/mm_timer.sv
// countdown timer with an interrupt mask, raises the timer interrupt until the core acknowledges it
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module mm_timer (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    mask_we_i,
    input  logic                    count_we_i,
    input  mm_ram_pkg::word_t       wdata_i,
    input  logic                    irq_ack_i,
    input  mm_ram_pkg::irq_id_t     irq_id_i,
    output logic                    irq_timer_o
);
    import mm_ram_pkg::*;

    // only the timer bit of the mask register has an effect
    logic  mask_q;
    word_t count_q;
    logic  irq_q;
    logic  timer_write;
    logic  expire;
    logic  ack;

    assign timer_write = mask_we_i || count_we_i;

    // counter steps from 1 to 0 on this edge
    assign expire = !timer_write && (count_q == word_t'(1));

    assign ack = irq_ack_i && (irq_id_i == irq_id_t'(`MM_TIMER_IRQ_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q  <= 1'b0;
            count_q <= '0;
            irq_q   <= 1'b0;
        end else begin
            // a mask write wins over a count write
            if (mask_we_i) begin
                mask_q <= wdata_i[`MM_TIMER_IRQ_ID];
            end else if (count_we_i) begin
                count_q <= wdata_i;
            end else if (count_q != '0) begin
                count_q <= count_q - word_t'(1);
            end

            // acknowledge has priority over a new expiry
            if (ack) begin
                irq_q <= 1'b0;
            end else if (expire && mask_q) begin
                irq_q <= 1'b1;
            end
        end
    end

    assign irq_timer_o = irq_q;

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_mm_ram -o tb_mm_ram \
    && ./obj_dir/tb_mm_ram +verilator+error+limit+100 \
    || { echo "simulation did not complete cleanly"; exit 1; }

//--- tests/mm_ram_checker.sv
// concurrent protocol assertions, bound to the memory top level by the testbench
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module mm_ram_checker (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 instr_req_i,
    input logic                 instr_gnt_o,
    input logic                 instr_rvalid_o,
    input logic                 data_req_i,
    input logic                 data_we_i,
    input logic                 data_gnt_o,
    input logic                 data_rvalid_o,
    input mm_ram_pkg::word_t    data_addr_i,
    input mm_ram_pkg::word_t    data_wdata_i,
    input mm_ram_pkg::word_t    data_rdata_o,
    input logic                 irq_ack_i,
    input mm_ram_pkg::irq_id_t  irq_id_i,
    input logic                 irq_timer_o,
    input logic                 tests_passed_o,
    input logic                 tests_failed_o,
    input logic                 exit_valid_o,
    input mm_ram_pkg::word_t    exit_value_o
);
    import mm_ram_pkg::*;

    int unsigned fail_cnt = 0;
    logic        status_wr;
    logic        exit_wr;
    logic        far_read;

    assign status_wr = data_req_i && data_we_i && (data_addr_i == `MM_ADDR_STATUS);
    assign exit_wr   = data_req_i && data_we_i && (data_addr_i == `MM_ADDR_EXIT);
    // read outside RAM, must come back as zero
    assign far_read  = data_req_i && !data_we_i &&
                       (data_addr_i >= (word_t'(1) << `MM_RAM_ADDR_WIDTH));

    a_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_gnt_o == data_req_i && instr_gnt_o == instr_req_i)
        else begin $error("grant does not follow the request"); fail_cnt++; end

    a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_o == $past(data_req_i) && instr_rvalid_o == $past(instr_req_i))
        else begin $error("rvalid not one cycle after the grant"); fail_cnt++; end

    a_far_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        far_read |=> data_rdata_o == '0)
        else begin $error("read outside RAM returned nonzero data"); fail_cnt++; end

    a_status: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tests_passed_o == (status_wr && data_wdata_i == `MM_STATUS_PASS_CODE) &&
        tests_failed_o == (status_wr && data_wdata_i == `MM_STATUS_FAIL_CODE))
        else begin $error("pass or fail flag wrong for the status write"); fail_cnt++; end

    a_exit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exit_valid_o == exit_wr && (!exit_wr || exit_value_o == data_wdata_i))
        else begin $error("exit flag or exit value wrong"); fail_cnt++; end

    a_irq_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        irq_ack_i && irq_id_i == irq_id_t'(`MM_TIMER_IRQ_ID) |=> !irq_timer_o)
        else begin $error("timer interrupt not cleared by the acknowledge"); fail_cnt++; end

endmodule

//--- tests/tb_clock_gen.sv
// clock and reset source for the testbench, reset released after a fixed number of cycles
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rst_no = 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- tests/tb_mm_ram.sv
// testbench top, runs RAM, fetch, status and timer traffic against the simulation memory
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module tb_mm_ram;
    localparam int CLK_PERIOD     = 20;
    localparam int PLANNED_CYCLES = 120;
    localparam int TIMER_N        = 5;

    logic clk, rst_n;
    logic instr_req_i, instr_gnt_o, instr_rvalid_o;
    logic [15:0] instr_addr_i;
    logic [127:0] instr_rdata_o;
    logic data_req_i, data_we_i, data_gnt_o, data_rvalid_o;
    logic [3:0] data_be_i;
    logic [31:0] data_addr_i, data_wdata_i, data_rdata_o, exit_value_o;
    logic [5:0] irq_id_i;
    logic irq_ack_i, irq_timer_o, tests_passed_o, tests_failed_o, exit_valid_o;
    logic [15:0] lfsr_q = 16'd39909;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) clock_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    mm_ram_top dut_i (.clk_i(clk), .rst_ni(rst_n), .*);

    bind mm_ram_top mm_ram_checker checker_i (.*);

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // one request, then wait for its rvalid
    task automatic data_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        int n;
        data_req_i = 1'b1;
        data_we_i = we;
        data_addr_i = addr;
        data_wdata_i = wdata;
        data_be_i = 4'hf;
        tick();
        data_req_i = 1'b0;
        data_we_i = 1'b0;
        n = 0;
        while (!data_rvalid_o) begin
            if (n == 8) fail_now("data port gave no rvalid");
            tick();
            n++;
        end
        rdata = data_rdata_o;
    endtask

    task automatic fetch_line(input logic [15:0] addr, output logic [127:0] line);
        int n;
        instr_req_i = 1'b1;
        instr_addr_i = addr;
        tick();
        instr_req_i = 1'b0;
        n = 0;
        while (!instr_rvalid_o) begin
            if (n == 8) fail_now("instruction port gave no rvalid");
            tick();
            n++;
        end
        line = instr_rdata_o;
    endtask

    always @(negedge clk) begin
        if (dut_i.checker_i.fail_cnt != 0) fail_now("a protocol assertion in the checker failed");
    end

    initial begin
        #(2 * PLANNED_CYCLES * CLK_PERIOD);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] addr, wdata, rdata;
        logic [127:0] line;
        instr_req_i = 0;
        instr_addr_i = 0;
        data_req_i = 0;
        data_addr_i = 0;
        data_we_i = 0;
        data_be_i = 0;
        data_wdata_i = 0;
        irq_id_i = 0;
        irq_ack_i = 0;
        @(posedge rst_n);
        tick();
        repeat (8) begin
            addr = rand_bits(12) << 4;
            wdata = rand_bits(32);
            data_access(1'b1, addr, wdata, rdata);
            data_access(1'b0, addr, 32'h0, rdata);
            assert (rdata === wdata)
                else fail_now($sformatf("FAIL data_rdata_o got %h expected %h", rdata, wdata));
            fetch_line(addr[15:0], line);
            assert (line[31:0] === wdata)
                else fail_now($sformatf("FAIL instr_rdata_o got %h expected %h", line[31:0], wdata));
        end
        // far address whose low bits hit the last written RAM word
        data_access(1'b0, 32'h3000_0000 | addr, 32'h0, rdata);
        // back-to-back requests on both ports
        instr_req_i = 1'b1;
        data_req_i = 1'b1;
        repeat (3) begin
            instr_addr_i = 16'(rand_bits(16));
            data_addr_i = rand_bits(16);
            tick();
        end
        instr_req_i = 1'b0;
        data_req_i = 1'b0;
        tick();
        data_access(1'b1, `MM_ADDR_STATUS, `MM_STATUS_PASS_CODE, rdata);
        data_access(1'b1, `MM_ADDR_STATUS, `MM_STATUS_FAIL_CODE, rdata);
        data_access(1'b1, `MM_ADDR_EXIT, rand_bits(8), rdata);
        // timer with the mask bit set, irq after N edges
        data_access(1'b1, `MM_ADDR_TIMER_MASK, 32'h80, rdata);
        data_access(1'b1, `MM_ADDR_TIMER_COUNT, TIMER_N, rdata);
        repeat (TIMER_N - 1) begin
            tick();
            assert (!irq_timer_o) else fail_now("FAIL irq_timer_o got 1 expected 0");
        end
        tick();
        assert (irq_timer_o) else fail_now("FAIL irq_timer_o got 0 expected 1");
        irq_ack_i = 1'b1;
        irq_id_i = `MM_TIMER_IRQ_ID;
        tick();
        irq_ack_i = 1'b0;
        // mask clear, no interrupt
        data_access(1'b1, `MM_ADDR_TIMER_MASK, 32'h0, rdata);
        data_access(1'b1, `MM_ADDR_TIMER_COUNT, 32'd3, rdata);
        repeat (6) begin
            tick();
            assert (!irq_timer_o) else fail_now("FAIL irq_timer_o got 1 expected 0");
        end
        tick();
        if (dut_i.checker_i.fail_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_now("a protocol assertion in the checker failed");
        end
    end

endmodule

//--- verilog.f
+incdir+include
logic/mm_ram_pkg.sv
logic/mm_test_status.sv
logic/mm_timer.sv
logic/mm_dp_ram.sv
logic/mm_addr_decode.sv
logic/mm_ram_top.sv
tests/tb_clock_gen.sv
tests/mm_ram_checker.sv
tests/tb_mm_ram.sv
